// ==== hw/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

    parameter int XLEN       = 32;
    parameter int REG_ADDR_W = 5;
    parameter int ISSUE_W    = 2;

    // 3R opcodes, instruction bits 31..15
    parameter logic [16:0] OP_3R_ADD = 17'h00020; // add.w
    parameter logic [16:0] OP_3R_SUB = 17'h00022; // sub.w
    parameter logic [16:0] OP_3R_AND = 17'h00029;
    parameter logic [16:0] OP_3R_OR  = 17'h0002a;
    parameter logic [16:0] OP_3R_XOR = 17'h0002b;

    // 2RI12 opcodes, instruction bits 31..22
    parameter logic [9:0] OP_RI12_ADDI = 10'h00a; // addi.w
    parameter logic [9:0] OP_RI12_ANDI = 10'h00d;
    parameter logic [9:0] OP_RI12_ORI  = 10'h00e;

    // one instruction word, two field layouts
    typedef union packed {
        struct packed {
            logic [16:0] op;
            logic [4:0]  rk;
            logic [4:0]  rj;
            logic [4:0]  rd;
        } r3;
        struct packed {
            logic [9:0]  op;
            logic [11:0] imm;
            logic [4:0]  rj;
            logic [4:0]  rd;
        } ri12;
    } insn_u;

    typedef enum logic [2:0] {
        ALU_NONE = 3'd0,
        ALU_ADD  = 3'd1,
        ALU_SUB  = 3'd2,
        ALU_AND  = 3'd3,
        ALU_OR   = 3'd4,
        ALU_XOR  = 3'd5
    } alu_op_e;

    // ALU_NONE means the word is not one of the kept instructions
    function automatic alu_op_e insn_alu_op(insn_u w);
        alu_op_e op;
        case (w.r3.op)
            OP_3R_ADD: op = ALU_ADD;
            OP_3R_SUB: op = ALU_SUB;
            OP_3R_AND: op = ALU_AND;
            OP_3R_OR:  op = ALU_OR;
            OP_3R_XOR: op = ALU_XOR;
            default: begin
                case (w.ri12.op)
                    OP_RI12_ADDI: op = ALU_ADD;
                    OP_RI12_ANDI: op = ALU_AND;
                    OP_RI12_ORI:  op = ALU_OR;
                    default:      op = ALU_NONE;
                endcase
            end
        endcase
        return op;
    endfunction

    // only 3R words read rk
    function automatic logic insn_is_3r(insn_u w);
        return w.r3.op inside {OP_3R_ADD, OP_3R_SUB, OP_3R_AND, OP_3R_OR, OP_3R_XOR};
    endfunction

endpackage

`default_nettype wire

// ==== hw/dual_issue_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module dual_issue_core #(
    parameter int BUF_DEPTH = 4
) (
    input  logic                           clk,
    input  logic                           i_rst,
    input  logic                           i_push,
    input  logic [cpu_pkg::XLEN-1:0]       i_ir0,
    input  logic [cpu_pkg::XLEN-1:0]       i_ir1,
    output logic                           o_full,
    output logic [cpu_pkg::ISSUE_W-1:0]    o_wb_we,
    output logic [cpu_pkg::REG_ADDR_W-1:0] o_wb_wnum [cpu_pkg::ISSUE_W],
    output logic [cpu_pkg::XLEN-1:0]       o_wb_wdata [cpu_pkg::ISSUE_W]
);

    // buffer -> issue
    logic [cpu_pkg::XLEN-1:0]       head_ir0;
    logic [cpu_pkg::XLEN-1:0]       head_ir1;
    logic [1:0]                     head_valid;
    logic [1:0]                     take;

    // register read
    logic [cpu_pkg::REG_ADDR_W-1:0] raddr [2*cpu_pkg::ISSUE_W];
    logic [cpu_pkg::XLEN-1:0]       rdata [2*cpu_pkg::ISSUE_W];

    // issue regs -> lanes
    logic [cpu_pkg::ISSUE_W-1:0]    iss_valid;
    logic [cpu_pkg::XLEN-1:0]       iss_ir [cpu_pkg::ISSUE_W];
    logic [cpu_pkg::XLEN-1:0]       iss_src1 [cpu_pkg::ISSUE_W];
    logic [cpu_pkg::XLEN-1:0]       iss_src2 [cpu_pkg::ISSUE_W];

    // lane result regs -> writeback and scoreboard
    logic [cpu_pkg::ISSUE_W-1:0]    lane_valid;
    logic [cpu_pkg::REG_ADDR_W-1:0] lane_rd [cpu_pkg::ISSUE_W];
    logic [cpu_pkg::XLEN-1:0]       lane_result [cpu_pkg::ISSUE_W];

    instr_buffer #(
        .BUF_DEPTH (BUF_DEPTH)
    ) u_instr_buffer (
        .clk          (clk),
        .i_rst        (i_rst),
        .i_push       (i_push),
        .i_ir0        (i_ir0),
        .i_ir1        (i_ir1),
        .i_take       (take),
        .o_head_ir0   (head_ir0),
        .o_head_ir1   (head_ir1),
        .o_head_valid (head_valid),
        .o_full       (o_full)
    );

    issue_dispatch u_issue_dispatch (
        .clk            (clk),
        .i_rst          (i_rst),
        .i_head_ir0     (head_ir0),
        .i_head_ir1     (head_ir1),
        .i_head_valid   (head_valid),
        .o_take         (take),
        .o_raddr        (raddr),
        .i_rdata        (rdata),
        .i_lane_busy_rd (lane_rd),
        .i_lane_busy    (lane_valid),
        .o_iss_valid    (iss_valid),
        .o_iss_ir       (iss_ir),
        .o_iss_src1     (iss_src1),
        .o_iss_src2     (iss_src2)
    );

    //////////////////////////////////////////////////
    // execute lanes, lane 0 holds the older word

    for (genvar g = 0; g < cpu_pkg::ISSUE_W; g++) begin : gen_lane
        exe_lane u_exe_lane (
            .clk      (clk),
            .i_rst    (i_rst),
            .i_valid  (iss_valid[g]),
            .i_ir     (iss_ir[g]),
            .i_src1   (iss_src1[g]),
            .i_src2   (iss_src2[g]),
            .o_valid  (lane_valid[g]),
            .o_rd     (lane_rd[g]),
            .o_result (lane_result[g])
        );
    end

    writeback_rf u_writeback_rf (
        .clk        (clk),
        .i_rst      (i_rst),
        .i_wb_valid (lane_valid),
        .i_wb_rd    (lane_rd),
        .i_wb_data  (lane_result),
        .i_raddr    (raddr),
        .o_rdata    (rdata),
        .o_wb_we    (o_wb_we),
        .o_wb_wnum  (o_wb_wnum),
        .o_wb_wdata (o_wb_wdata)
    );

endmodule

`default_nettype wire

// ==== hw/exe_lane.sv ====
`timescale 1ns/1ps
`default_nettype none

module exe_lane (
    input  logic                           clk,
    input  logic                           i_rst,
    input  logic                           i_valid,
    input  logic [cpu_pkg::XLEN-1:0]       i_ir,
    input  logic [cpu_pkg::XLEN-1:0]       i_src1,
    input  logic [cpu_pkg::XLEN-1:0]       i_src2,
    output logic                           o_valid,
    output logic [cpu_pkg::REG_ADDR_W-1:0] o_rd,
    output logic [cpu_pkg::XLEN-1:0]       o_result
);

    localparam int EXT_W = cpu_pkg::XLEN - 12;

    cpu_pkg::insn_u           ir;
    cpu_pkg::alu_op_e         alu_op;
    logic                     imm_form;
    logic [cpu_pkg::XLEN-1:0] imm_ext;
    logic [cpu_pkg::XLEN-1:0] op_b;
    logic [cpu_pkg::XLEN-1:0] alu_out;
    logic                     writes;

    assign ir       = i_ir;
    assign alu_op   = cpu_pkg::insn_alu_op(ir);
    assign imm_form = !cpu_pkg::insn_is_3r(ir);

    // only addi.w maps to add in the immediate form, so it alone is signed
    assign imm_ext = (alu_op == cpu_pkg::ALU_ADD)
                   ? {{EXT_W{ir.ri12.imm[11]}}, ir.ri12.imm}
                   : {{EXT_W{1'b0}}, ir.ri12.imm};

    assign op_b = imm_form ? imm_ext : i_src2;

    //////////////////////////////////////////////////
    // alu

    always_comb begin
        case (alu_op)
            cpu_pkg::ALU_ADD: alu_out = i_src1 + op_b;
            cpu_pkg::ALU_SUB: alu_out = i_src1 - op_b;
            cpu_pkg::ALU_AND: alu_out = i_src1 & op_b;
            cpu_pkg::ALU_OR:  alu_out = i_src1 | op_b;
            cpu_pkg::ALU_XOR: alu_out = i_src1 ^ op_b;
            default:          alu_out = '0;  // unknown word
        endcase
    end

    // unknown opcode or r0 target retires without a write
    assign writes = (alu_op != cpu_pkg::ALU_NONE) && (ir.r3.rd != '0);

    always_ff @(posedge clk) begin
        if (i_rst)
            o_valid <= 1'b0;
        else
            o_valid <= i_valid && writes;
    end

    always_ff @(posedge clk) begin
        o_rd     <= ir.r3.rd;  // rd sits in the same bits in both views
        o_result <= alu_out;
    end

endmodule

`default_nettype wire

// ==== hw/instr_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_buffer #(
    parameter int BUF_DEPTH = 4
) (
    input  logic                     clk,
    input  logic                     i_rst,
    input  logic                     i_push,
    input  logic [cpu_pkg::XLEN-1:0] i_ir0,
    input  logic [cpu_pkg::XLEN-1:0] i_ir1,
    input  logic [1:0]               i_take,
    output logic [cpu_pkg::XLEN-1:0] o_head_ir0,
    output logic [cpu_pkg::XLEN-1:0] o_head_ir1,
    output logic [1:0]               o_head_valid,
    output logic                     o_full
);

    localparam int PTR_W = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;
    localparam int CNT_W = $clog2(BUF_DEPTH + 1);

    logic [cpu_pkg::XLEN-1:0] mem_ir0 [BUF_DEPTH];
    logic [cpu_pkg::XLEN-1:0] mem_ir1 [BUF_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             half_taken;  // older word of head already issued
    logic             do_push;
    logic             do_pop;
    logic             not_empty;

    assign not_empty = (count != '0);
    assign o_full    = (count == CNT_W'(BUF_DEPTH));
    assign do_push   = i_push && !o_full;  // push while full is dropped

    // head leaves once both of its words are gone
    assign do_pop = not_empty && (half_taken ? (i_take != 2'd0) : (i_take == 2'd2));

    assign o_head_ir0   = mem_ir0[rd_ptr];
    assign o_head_ir1   = mem_ir1[rd_ptr];
    assign o_head_valid = !not_empty ? 2'b00 : (half_taken ? 2'b01 : 2'b11);

    //////////////////////////////////////////////////
    // pointers, count, half flag

    always_ff @(posedge clk) begin
        if (i_rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            half_taken <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(BUF_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(BUF_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            if (do_pop)
                half_taken <= 1'b0;
            else if (not_empty && !half_taken && i_take == 2'd1)
                half_taken <= 1'b1;  // split pair, younger stays
        end
    end

    // pair storage
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem_ir0[wr_ptr] <= i_ir0;
            mem_ir1[wr_ptr] <= i_ir1;
        end
    end

endmodule

`default_nettype wire

// ==== hw/issue_dispatch.sv ====
`timescale 1ns/1ps
`default_nettype none

module issue_dispatch (
    input  logic                           clk,
    input  logic                           i_rst,
    input  logic [cpu_pkg::XLEN-1:0]       i_head_ir0,
    input  logic [cpu_pkg::XLEN-1:0]       i_head_ir1,
    input  logic [1:0]                     i_head_valid,
    output logic [1:0]                     o_take,
    output logic [cpu_pkg::REG_ADDR_W-1:0] o_raddr [2*cpu_pkg::ISSUE_W],
    input  logic [cpu_pkg::XLEN-1:0]       i_rdata [2*cpu_pkg::ISSUE_W],
    input  logic [cpu_pkg::REG_ADDR_W-1:0] i_lane_busy_rd [cpu_pkg::ISSUE_W],
    input  logic [cpu_pkg::ISSUE_W-1:0]    i_lane_busy,
    output logic [cpu_pkg::ISSUE_W-1:0]    o_iss_valid,
    output logic [cpu_pkg::XLEN-1:0]       o_iss_ir [cpu_pkg::ISSUE_W],
    output logic [cpu_pkg::XLEN-1:0]       o_iss_src1 [cpu_pkg::ISSUE_W],
    output logic [cpu_pkg::XLEN-1:0]       o_iss_src2 [cpu_pkg::ISSUE_W]
);

    localparam int NREG = 2 ** cpu_pkg::REG_ADDR_W;

    cpu_pkg::insn_u                cand_ir [cpu_pkg::ISSUE_W];  // [0] is always the oldest
    logic [cpu_pkg::ISSUE_W-1:0]   cand_v;
    logic [cpu_pkg::ISSUE_W-1:0]   use_rj;
    logic [cpu_pkg::ISSUE_W-1:0]   use_rk;
    logic [cpu_pkg::ISSUE_W-1:0]   src_hit;
    cpu_pkg::insn_u                iss_word [cpu_pkg::ISSUE_W];
    logic [NREG-1:0]               busy_mask;
    logic                          older_wr;
    logic                          pair_hit;
    logic                          issue0;
    logic                          issue1;

    //////////////////////////////////////////////////
    // candidate words

    always_comb begin
        cand_v[0]  = |i_head_valid;
        cand_ir[0] = i_head_valid[1] ? i_head_ir0 : i_head_ir1;  // 01 -> only younger left
        cand_v[1]  = &i_head_valid;
        cand_ir[1] = i_head_ir1;
        for (int k = 0; k < cpu_pkg::ISSUE_W; k++) begin
            use_rj[k] = (cpu_pkg::insn_alu_op(cand_ir[k]) != cpu_pkg::ALU_NONE);
            use_rk[k] = cpu_pkg::insn_is_3r(cand_ir[k]);
            o_raddr[2*k]   = cand_ir[k].r3.rj;
            o_raddr[2*k+1] = cand_ir[k].r3.rk;
        end
    end

    // scoreboard: destinations in the issue regs and lane result regs
    always_comb begin
        busy_mask = '0;
        for (int k = 0; k < cpu_pkg::ISSUE_W; k++) begin
            iss_word[k] = o_iss_ir[k];
            if (o_iss_valid[k] && cpu_pkg::insn_alu_op(iss_word[k]) != cpu_pkg::ALU_NONE)
                busy_mask[iss_word[k].r3.rd] = 1'b1;
            if (i_lane_busy[k])
                busy_mask[i_lane_busy_rd[k]] = 1'b1;
        end
        busy_mask[0] = 1'b0;  // r0 never blocks
    end

    always_comb begin
        for (int k = 0; k < cpu_pkg::ISSUE_W; k++) begin
            src_hit[k] = (use_rj[k] && busy_mask[cand_ir[k].r3.rj])
                      || (use_rk[k] && busy_mask[cand_ir[k].r3.rk]);
        end
    end

    //////////////////////////////////////////////////
    // pair hazard and issue decision

    assign older_wr = (cpu_pkg::insn_alu_op(cand_ir[0]) != cpu_pkg::ALU_NONE)
                   && (cand_ir[0].r3.rd != '0);

    // younger reads what the older one writes
    assign pair_hit = older_wr
                   && ((use_rj[1] && cand_ir[1].r3.rj == cand_ir[0].r3.rd)
                    || (use_rk[1] && cand_ir[1].r3.rk == cand_ir[0].r3.rd));

    assign issue0 = cand_v[0] && !src_hit[0];
    assign issue1 = issue0 && cand_v[1] && !src_hit[1] && !pair_hit;
    assign o_take = issue1 ? 2'd2 : (issue0 ? 2'd1 : 2'd0);

    always_ff @(posedge clk) begin
        if (i_rst)
            o_iss_valid <= '0;
        else
            o_iss_valid <= {issue1, issue0};
    end

    // payload, qualified by o_iss_valid
    always_ff @(posedge clk) begin
        for (int k = 0; k < cpu_pkg::ISSUE_W; k++) begin
            o_iss_ir[k]   <= cand_ir[k];
            o_iss_src1[k] <= i_rdata[2*k];
            o_iss_src2[k] <= i_rdata[2*k+1];
        end
    end

endmodule

`default_nettype wire

// ==== hw/writeback_rf.sv ====
`timescale 1ns/1ps
`default_nettype none

module writeback_rf (
    input  logic                           clk,
    input  logic                           i_rst,
    input  logic [cpu_pkg::ISSUE_W-1:0]    i_wb_valid,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] i_wb_rd [cpu_pkg::ISSUE_W],
    input  logic [cpu_pkg::XLEN-1:0]       i_wb_data [cpu_pkg::ISSUE_W],
    input  logic [cpu_pkg::REG_ADDR_W-1:0] i_raddr [2*cpu_pkg::ISSUE_W],
    output logic [cpu_pkg::XLEN-1:0]       o_rdata [2*cpu_pkg::ISSUE_W],
    output logic [cpu_pkg::ISSUE_W-1:0]    o_wb_we,
    output logic [cpu_pkg::REG_ADDR_W-1:0] o_wb_wnum [cpu_pkg::ISSUE_W],
    output logic [cpu_pkg::XLEN-1:0]       o_wb_wdata [cpu_pkg::ISSUE_W]
);

    localparam int NREG = 2 ** cpu_pkg::REG_ADDR_W;

    logic [cpu_pkg::XLEN-1:0]    regs [NREG];
    logic [cpu_pkg::ISSUE_W-1:0] wb_we;

    always_comb begin
        for (int k = 0; k < cpu_pkg::ISSUE_W; k++) begin
            wb_we[k] = i_wb_valid[k] && (i_wb_rd[k] != '0);  // r0 stays zero
        end
    end

    //////////////////////////////////////////////////
    // register array, lane 1 written last so it wins

    always_ff @(posedge clk) begin
        if (i_rst) begin
            for (int r = 0; r < NREG; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int k = 0; k < cpu_pkg::ISSUE_W; k++) begin
                if (wb_we[k])
                    regs[i_wb_rd[k]] <= i_wb_data[k];
            end
        end
    end

    // read ports with write-through, r0 reads zero since it is never written
    always_comb begin
        for (int p = 0; p < 2*cpu_pkg::ISSUE_W; p++) begin
            o_rdata[p] = regs[i_raddr[p]];
            for (int k = 0; k < cpu_pkg::ISSUE_W; k++) begin
                if (wb_we[k] && i_wb_rd[k] == i_raddr[p])
                    o_rdata[p] = i_wb_data[k];  // younger lane overrides
            end
        end
    end

    // debug style report of every write, same cycle as the array update
    assign o_wb_we = wb_we;

    always_comb begin
        for (int k = 0; k < cpu_pkg::ISSUE_W; k++) begin
            o_wb_wnum[k]  = i_wb_rd[k];
            o_wb_wdata[k] = i_wb_data[k];
        end
    end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build and run with Verilator, then look for the fail line in sim.log
rm -f sim.log
verilator --binary --timing --assert -f verilog.f --top-module tb_dual_issue_core \
    -o sim_tb > build.log 2>&1 \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    || echo "Test FAILED" >> sim.log
cat sim.log
grep -q "Test FAILED" sim.log && exit 1 || exit 0

// ==== test/core_trace.txt ====
// columns: tag word_a word_b, all hex
// tag 1 pushes pair (ir0 ir1), tag 2 expects write (reg value), tag 0 ends
1 02848C01 02BFFC02
2 00000001 00000123
2 00000002 FFFFFFFF
1 0363C043 03A00004
2 00000003 000008F0
2 00000004 00000800
1 00101025 001104A6
2 00000005 00000923
2 00000006 00000800
1 00149447 00151068
2 00000007 00000923
2 00000008 000008F0
1 00158449 0011040A
2 00000009 FFFFFEDC
2 0000000A FFFFFEDD
1 02801420 FFFFFFFF
1 0015012B 029FFC0C
2 0000000B FFFFFEDC
2 0000000C 000007FF
1 00000000 02A0000D
2 0000000D FFFFF800
1 0280040E 0280080E
2 0000000E 00000001
2 0000000E 00000002
1 001039CF 03400000
2 0000000F 00000004
1 02800610 02800610
1 02800610 02800610
1 02800610 02800610
1 02800610 02800610
1 02800610 02800610
1 02800610 02800610
2 00000010 00000001
2 00000010 00000002
2 00000010 00000003
2 00000010 00000004
2 00000010 00000005
2 00000010 00000006
2 00000010 00000007
2 00000010 00000008
2 00000010 00000009
2 00000010 0000000A
2 00000010 0000000B
2 00000010 0000000C
0 00000000 00000000

// ==== test/dual_issue_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module dual_issue_props #(
    parameter int BUF_DEPTH = 4
) (
    input logic                           clk,
    input logic                           i_rst,
    input logic [cpu_pkg::ISSUE_W-1:0]    i_wb_we,
    input logic [cpu_pkg::REG_ADDR_W-1:0] i_wb_wnum [cpu_pkg::ISSUE_W],
    input logic [cpu_pkg::ISSUE_W-1:0]    i_iss_valid,
    input logic [cpu_pkg::XLEN-1:0]       i_iss_ir [cpu_pkg::ISSUE_W],
    input logic [$clog2(BUF_DEPTH+1)-1:0] i_buf_count
);

    localparam int CNT_W = $clog2(BUF_DEPTH + 1);

    logic [16:0] lane0_op3;
    logic [9:0]  lane0_op12;
    logic        lane0_kept;
    logic        lane0_nowrite;  // issued word that retires silently

    assign lane0_op3  = i_iss_ir[0][31:15];
    assign lane0_op12 = i_iss_ir[0][31:22];
    assign lane0_kept = (lane0_op3 inside {cpu_pkg::OP_3R_ADD, cpu_pkg::OP_3R_SUB,
                                           cpu_pkg::OP_3R_AND, cpu_pkg::OP_3R_OR,
                                           cpu_pkg::OP_3R_XOR})
                     || (lane0_op12 inside {cpu_pkg::OP_RI12_ADDI, cpu_pkg::OP_RI12_ANDI,
                                            cpu_pkg::OP_RI12_ORI});
    assign lane0_nowrite = i_iss_valid[0] && (!lane0_kept || i_iss_ir[0][4:0] == '0);

    a_wb0_not_r0: assert property (@(posedge clk) disable iff (i_rst)
        i_wb_we[0] |-> i_wb_wnum[0] != '0)
        else $error("lane 0 reported a write to r0");

    a_wb1_not_r0: assert property (@(posedge clk) disable iff (i_rst)
        i_wb_we[1] |-> i_wb_wnum[1] != '0)
        else $error("lane 1 reported a write to r0");

    // lane 1 alone only behind a silent lane 0 word
    a_lane1_alone: assert property (@(posedge clk) disable iff (i_rst)
        (i_wb_we[1] && !i_wb_we[0]) |-> $past(lane0_nowrite))
        else $error("lane 1 wrote while lane 0 dropped a real write");

    a_buf_count: assert property (@(posedge clk) disable iff (i_rst)
        i_buf_count <= CNT_W'(BUF_DEPTH))
        else $error("instruction buffer count above its depth");

endmodule

bind dual_issue_core dual_issue_props #(
    .BUF_DEPTH (BUF_DEPTH)
) u_dual_issue_props (
    .clk         (clk),
    .i_rst       (i_rst),
    .i_wb_we     (o_wb_we),
    .i_wb_wnum   (o_wb_wnum),
    .i_iss_valid (iss_valid),
    .i_iss_ir    (iss_ir),
    .i_buf_count (u_instr_buffer.count)
);

`default_nettype wire

// ==== test/tb_dual_issue_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_dual_issue_core;

    localparam int BUF_DEPTH   = 4;
    localparam int TRACE_WORDS = 3 * 64;  // tag, word a, word b per record
    localparam int WAIT_LIMIT  = 200;     // cycles

    logic                           clk;
    logic                           i_rst;
    logic                           i_push;
    logic [cpu_pkg::XLEN-1:0]       i_ir0;
    logic [cpu_pkg::XLEN-1:0]       i_ir1;
    logic                           o_full;
    logic [cpu_pkg::ISSUE_W-1:0]    o_wb_we;
    logic [cpu_pkg::REG_ADDR_W-1:0] o_wb_wnum [cpu_pkg::ISSUE_W];
    logic [cpu_pkg::XLEN-1:0]       o_wb_wdata [cpu_pkg::ISSUE_W];

    logic [31:0] trace_mem [TRACE_WORDS];
    logic [31:0] push_ir0 [$];
    logic [31:0] push_ir1 [$];
    logic [4:0]  exp_reg [$];
    logic [31:0] exp_val [$];
    int          value_errors;
    int          other_errors;
    int          writes_seen;
    bit          full_seen;
    bit          timed_out;

    dual_issue_core #(
        .BUF_DEPTH (BUF_DEPTH)
    ) u_dual_issue_core (
        .clk        (clk),
        .i_rst      (i_rst),
        .i_push     (i_push),
        .i_ir0      (i_ir0),
        .i_ir1      (i_ir1),
        .o_full     (o_full),
        .o_wb_we    (o_wb_we),
        .o_wb_wnum  (o_wb_wnum),
        .o_wb_wdata (o_wb_wdata)
    );

    always #50 clk = ~clk;

    //////////////////////////////////////////////////
    // tag 1 holds a pair and tag 2 an expected write until a tag 0 record

    task automatic load_trace();
        int          idx;
        logic [31:0] tag;
        for (int i = 0; i < TRACE_WORDS; i++) begin
            trace_mem[i] = '0;
        end
        $readmemh("test/core_trace.txt", trace_mem);
        idx = 0;
        while (idx + 2 < TRACE_WORDS && trace_mem[idx] != 32'd0) begin
            tag = trace_mem[idx];
            if (tag == 32'd1) begin
                push_ir0.push_back(trace_mem[idx+1]);
                push_ir1.push_back(trace_mem[idx+2]);
            end else if (tag == 32'd2) begin
                exp_reg.push_back(trace_mem[idx+1][4:0]);
                exp_val.push_back(trace_mem[idx+2]);
            end else begin
                $display("trace record %0d has an unknown tag %h", idx / 3, tag);
                other_errors++;
            end
            idx += 3;
        end
        if (push_ir0.size() == 0) begin
            $display("trace file held no instruction pairs");
            other_errors++;
        end
    endtask

    // starts right after a rising edge and returns on the edge that takes the pair
    task automatic push_pair(input logic [31:0] w0, input logic [31:0] w1);
        int waited;
        waited = 0;
        i_push <= 1'b1;
        i_ir0  <= w0;
        i_ir1  <= w1;
        @(negedge clk);
        while (o_full && waited < WAIT_LIMIT) begin
            waited++;
            @(negedge clk);
        end
        if (o_full) begin
            $display("%0t ns: buffer stayed full, pair %h %h never accepted", $time, w0, w1);
            other_errors++;
            timed_out = 1'b1;
        end
        @(posedge clk);
    endtask

    task automatic check_write(input int lane);
        logic [4:0]  want_reg;
        logic [31:0] want_val;
        writes_seen++;
        assert (exp_reg.size() != 0) else begin
            $display("%0t ns: lane %0d wrote r%0d with no expected write left",
                     $time, lane, o_wb_wnum[lane]);
            other_errors++;
        end
        if (exp_reg.size() != 0) begin
            want_reg = exp_reg.pop_front();
            want_val = exp_val.pop_front();
            assert (o_wb_wnum[lane] == want_reg) else begin
                $display("Error %0t ns: o_wb_wnum[%0d] expected %0d got %0d",
                         $time, lane, want_reg, o_wb_wnum[lane]);
                value_errors++;
            end
            assert (o_wb_wdata[lane] == want_val) else begin
                $display("Error %0t ns: o_wb_wdata[%0d] expected %h got %h",
                         $time, lane, want_val, o_wb_wdata[lane]);
                value_errors++;
            end
        end
    endtask

    // lane 0 carries the older write of a cycle
    always @(negedge clk) begin
        if (!i_rst) begin
            if (o_full)
                full_seen = 1'b1;
            for (int k = 0; k < cpu_pkg::ISSUE_W; k++) begin
                if (o_wb_we[k])
                    check_write(k);
            end
        end
    end

    //////////////////////////////////////////////////
    // main sequence

    initial begin
        int waited;
        clk          = 1'b0;
        i_rst        = 1'b1;
        i_push       = 1'b0;
        i_ir0        = '0;
        i_ir1        = '0;
        value_errors = 0;
        other_errors = 0;
        writes_seen  = 0;
        full_seen    = 1'b0;
        timed_out    = 1'b0;
        load_trace();
        repeat (15) @(posedge clk);
        @(negedge clk);  // reset state in the last reset cycle
        assert (o_full == 1'b0) else begin
            $display("Error %0t ns: o_full expected 0 got %b", $time, o_full);
            value_errors++;
        end
        assert (o_wb_we == '0) else begin
            $display("Error %0t ns: o_wb_we expected %b got %b",
                     $time, {cpu_pkg::ISSUE_W{1'b0}}, o_wb_we);
            value_errors++;
        end
        @(posedge clk);
        i_rst <= 1'b0;
        for (int p = 0; p < push_ir0.size() && !timed_out; p++) begin
            push_pair(push_ir0[p], push_ir1[p]);
        end
        i_push <= 1'b0;
        waited = 0;
        while (exp_reg.size() != 0 && waited < WAIT_LIMIT && !timed_out) begin
            @(posedge clk);
            waited++;
        end
        assert (exp_reg.size() == 0) else begin
            $display("%0t ns: %0d expected writes never appeared", $time, exp_reg.size());
            other_errors++;
        end
        repeat (8) @(posedge clk);  // quiet period for stray writes
        assert (full_seen) else begin
            $display("buffer never reported full during the burst");
            other_errors++;
        end
        $display("writes checked %0d, value errors %0d, other errors %0d",
                 writes_seen, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
hw/cpu_pkg.sv
hw/instr_buffer.sv
hw/issue_dispatch.sv
hw/exe_lane.sv
hw/writeback_rf.sv
hw/dual_issue_core.sv
test/dual_issue_props.sv
test/tb_dual_issue_core.sv
